// File: sim.f
rtl/convPkg.sv
rtl/kernelLoader.sv
rtl/columnWindow.sv
rtl/convFilter.sv
rtl/outputQuantizer.sv
rtl/convLayer.sv
verif/convLayer_asserts.sv
verif/convLayerTb.sv

// File: Bender.yml
package:
  name: conv_layer

sources:
  - files:
      - rtl/convPkg.sv
      - rtl/kernelLoader.sv
      - rtl/columnWindow.sv
      - rtl/convFilter.sv
      - rtl/outputQuantizer.sv
      - rtl/convLayer.sv
  - target: test
    files:
      - verif/convLayer_asserts.sv
      - verif/convLayerTb.sv

// File: verif/convLayerTb.sv
`timescale 1ns/1ps

module convLayerTb;

    import convPkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int READY_CYCLE  = RESET_CYCLES + 1 + KERNEL_SIZE;
    localparam int LATENCY      = 3;
    localparam int NUM_TESTS    = 5;

    logic       clk;
    logic       rst;
    logic       validIn;
    inColumnsT  inColumns;
    outColumnsT outColumns;
    logic       validOut;
    logic       ready;

    // Stimulus table, one entry per driven cycle
    bit         rowValid [$];
    int         rowTest [$];
    inColumnsT  rowCols [$];
    string      testNames [NUM_TESTS] = '{"input before ready", "back-to-back columns",
                                          "idle gaps", "saturation", "random columns"};

    // Reference window, index 0 is the oldest column
    inColumnsT  refWin [KERNEL_SIZE];
    int         refFill;
    outColumnsT expCols [$];
    int         expDue [$];
    int         expTest [$];

    int cycle;
    int cycleLimit;
    int seed;
    int checkCount;
    int errorCount;
    int testErrors [NUM_TESTS];
    int doneTests;
    int nextReport;
    int curTest;

    convLayer i_dut (
        .clk        (clk),
        .rst        (rst),
        .validIn    (validIn),
        .inColumns  (inColumns),
        .outColumns (outColumns),
        .validOut   (validOut),
        .ready      (ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Cycle count and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycleLimit) begin
            $display("Timeout: the run went past %0d cycles", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    // ======================================================================
    // Table construction
    // ======================================================================
    task automatic addRow(input int test, input bit valid,
                          input pixelT ch0 [COL_SIZE], input pixelT ch1 [COL_SIZE]);
        inColumnsT cols;
        for (int r = 0; r < COL_SIZE; r++) begin
            cols[0][r] = ch0[r];
            cols[1][r] = ch1[r];
        end
        rowValid.push_back(valid);
        rowTest.push_back(test);
        rowCols.push_back(cols);
    endtask

    task automatic buildTable();
        pixelT a [COL_SIZE];
        pixelT b [COL_SIZE];
        // Loud columns that would saturate if they got into the window
        repeat (3) addRow(0, 1'b1, '{default: 16'sh7FFF}, '{default: 16'sh7FFF});
        addRow(1, 1'b1, '{16'sh0100, 16'sh0080, 16'shFF80, 16'sh0040, 16'sh0000, 16'sh00C0},
                        '{16'sh0040, 16'shFF00, 16'sh0080, 16'sh0100, 16'shFFC0, 16'sh0020});
        addRow(1, 1'b1, '{16'shFFC0, 16'sh0100, 16'sh0040, 16'shFF00, 16'sh0080, 16'sh0010},
                        '{16'sh0080, 16'sh0040, 16'shFFC0, 16'sh0000, 16'sh0100, 16'shFF80});
        addRow(1, 1'b1, '{16'sh0020, 16'shFFE0, 16'sh0180, 16'sh0040, 16'shFF40, 16'sh0100},
                        '{16'sh00C0, 16'sh0000, 16'sh0040, 16'shFFC0, 16'sh0080, 16'sh0100});
        addRow(1, 1'b1, '{16'sh0100, 16'sh0100, 16'sh0100, 16'sh0100, 16'sh0100, 16'sh0100},
                        '{16'shFF00, 16'shFF00, 16'shFF00, 16'shFF00, 16'shFF00, 16'shFF00});
        addRow(1, 1'b1, '{16'sh0000, 16'sh0040, 16'sh0080, 16'sh00C0, 16'sh0100, 16'sh0140},
                        '{16'sh0140, 16'sh0100, 16'sh00C0, 16'sh0080, 16'sh0040, 16'sh0000});
        // Idle rows carry data that must stay out of the window
        addRow(2, 1'b0, '{default: 16'sh0300}, '{default: 16'sh0300});
        addRow(2, 1'b1, '{16'sh0080, 16'shFF80, 16'sh0080, 16'shFF80, 16'sh0080, 16'shFF80},
                        '{16'sh0040, 16'sh0040, 16'shFFC0, 16'shFFC0, 16'sh0100, 16'sh0000});
        addRow(2, 1'b0, '{default: 16'sh0300}, '{default: 16'sh0300});
        addRow(2, 1'b0, '{default: 16'shFD00}, '{default: 16'shFD00});
        addRow(2, 1'b1, '{16'sh0180, 16'sh0000, 16'shFFC0, 16'sh0020, 16'sh0060, 16'shFF00},
                        '{16'sh0000, 16'sh0100, 16'sh0080, 16'shFF80, 16'sh0040, 16'sh00C0});
        addRow(2, 1'b0, '{default: 16'sh0300}, '{default: 16'sh0300});
        addRow(2, 1'b1, '{16'shFF00, 16'sh0040, 16'sh0100, 16'sh0080, 16'shFFC0, 16'sh0020},
                        '{16'sh0060, 16'shFFA0, 16'sh0100, 16'sh0000, 16'sh0080, 16'shFF40});
        // Full scale, both signs
        repeat (3) addRow(3, 1'b1, '{default: 16'sh7FFF}, '{default: 16'sh7FFF});
        repeat (3) addRow(3, 1'b1, '{default: 16'sh8000}, '{default: 16'sh8000});
        // Random pixels within +-2.0
        repeat (20) begin
            for (int r = 0; r < COL_SIZE; r++) begin
                a[r] = pixelT'($random(seed) % 513);
                b[r] = pixelT'($random(seed) % 513);
            end
            addRow(4, 1'b1, a, b);
        end
    endtask

    // ======================================================================
    // Reference model and bookkeeping
    // ======================================================================
    // Sum over the window in full precision, floor back to Q8.8, clamp
    function automatic outColumnsT expectedOutput();
        outColumnsT result;
        longint     sum;
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int r = 0; r < OUT_COL_SIZE; r++) begin
                sum = longint'(BIASES[f]) * 256;
                for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                    for (int ch = 0; ch < IN_CHANNELS; ch++) begin
                        for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
                            sum = sum + longint'(refWin[kc][ch][r + kr])
                                * longint'(KERNELS[f][ch][kr][kc]);
                        end
                    end
                end
                sum = sum >>> FRAC_BITS;
                if (sum > 32767) begin
                    result[f][r] = 16'sh7FFF;
                end else if (sum < -32768) begin
                    result[f][r] = 16'sh8000;
                end else begin
                    result[f][r] = pixelT'(sum);
                end
            end
        end
        return result;
    endfunction

    function automatic void noteError(input int test);
        errorCount++;
        if (test >= 0 && test < NUM_TESTS) begin
            testErrors[test]++;
        end
    endfunction

    function automatic void dropHead();
        void'(expCols.pop_front());
        void'(expDue.pop_front());
        void'(expTest.pop_front());
    endfunction

    // A test is over once its rows are driven and none of its outputs is pending
    task automatic reportFinished();
        while (nextReport < doneTests && (expTest.size() == 0 || expTest[0] > nextReport)) begin
            $display("Test %0d %s: %0d errors", nextReport, testNames[nextReport],
                     testErrors[nextReport]);
            nextReport++;
        end
    endtask

    task automatic applyRow(input int i);
        bit accepted;
        curTest = rowTest[i];
        checkCount++;
        assert (ready == (cycle >= READY_CYCLE)) else begin
            $display("ERROR ready actual %h expected %h at cycle %0d",
                     ready, cycle >= READY_CYCLE, cycle);
            noteError(curTest);
        end
        validIn   = rowValid[i];
        inColumns = rowCols[i];
        accepted  = rowValid[i] && cycle >= READY_CYCLE;
        if (accepted) begin
            for (int k = 0; k < KERNEL_SIZE - 1; k++) begin
                refWin[k] = refWin[k + 1];
            end
            refWin[KERNEL_SIZE - 1] = rowCols[i];
            if (refFill < KERNEL_SIZE) begin
                refFill++;
            end
            if (refFill == KERNEL_SIZE) begin
                expCols.push_back(expectedOutput());
                expDue.push_back(cycle + LATENCY);
                expTest.push_back(curTest);
            end
        end
        if (i == rowValid.size() - 1 || rowTest[i + 1] != curTest) begin
            doneTests = curTest + 1;
        end
        reportFinished();
    endtask

    task automatic checkOutput();
        bit due;
        due = expDue.size() > 0 && expDue[0] == cycle;
        checkCount++;
        assert (due) else begin
            $display("Test %0d: validOut went high at cycle %0d with no output expected",
                     curTest, cycle);
            noteError(curTest);
        end
        if (due) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                for (int r = 0; r < OUT_COL_SIZE; r++) begin
                    assert (outColumns[f][r] == expCols[0][f][r]) else begin
                        $display("ERROR outColumns[%0d][%0d] actual %h expected %h at cycle %0d",
                                 f, r, outColumns[f][r], expCols[0][f][r], cycle);
                        noteError(expTest[0]);
                    end
                end
            end
            dropHead();
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (expDue.size() > 0) begin
                assert (expDue[0] >= cycle) else begin
                    $display("Test %0d: no output arrived for the column due at cycle %0d",
                             expTest[0], expDue[0]);
                    noteError(expTest[0]);
                    dropHead();
                end
            end
            if (validOut) begin
                checkOutput();
            end
            reportFinished();
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        rst       = 1'b1;
        validIn   = 1'b0;
        inColumns = '0;
        seed      = 32'h4762;
        buildTable();
        cycleLimit = rowValid.size() + RESET_CYCLES + 1 + KERNEL_SIZE + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int i = 0; i < rowValid.size(); i++) begin
            @(posedge clk);
            #10;
            applyRow(i);
        end
        @(posedge clk);
        #10;
        validIn = 1'b0;
        while (nextReport < NUM_TESTS) begin
            @(posedge clk);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verif/convLayer_asserts.sv
`timescale 1ns/1ps

module convLayerAsserts (
    input logic clk,
    input logic rst,
    input logic validIn,
    input logic ready,
    input logic kernelLoad,
    input logic validOut
);

    import convPkg::*;

    logic [$clog2(KERNEL_SIZE + 1)-1:0] acceptCount;
    logic accept;
    logic producing;

    assign accept    = validIn && ready;
    // This column completes a full window
    assign producing = accept && (acceptCount >= KERNEL_SIZE - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acceptCount <= '0;
        end else if (accept && acceptCount < KERNEL_SIZE) begin
            acceptCount <= acceptCount + 1'b1;
        end
    end

    // No output before the kernels are in place
    outNeedsReady: assert property (@(posedge clk) disable iff (rst) validOut |-> ready)
        else $error("validOut high while ready is low");

    // One idle cycle, then one load cycle per kernel column
    loadLength: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> !kernelLoad ##1 kernelLoad [* KERNEL_SIZE] ##1 !kernelLoad)
        else $error("kernelLoad not high for exactly KERNEL_SIZE cycles after reset");

    outAfterAccept: assert property (@(posedge clk) disable iff (rst)
        producing |-> ##3 validOut)
        else $error("validOut missing 3 cycles after an accepted column");

    noStrayOut: assert property (@(posedge clk) disable iff (rst)
        validOut |-> $past(producing, 3))
        else $error("validOut without an accepted column 3 cycles earlier");

endmodule

bind convLayer convLayerAsserts i_asserts (
    .clk        (clk),
    .rst        (rst),
    .validIn    (validIn),
    .ready      (ready),
    .kernelLoad (kernelLoad),
    .validOut   (validOut)
);

// File: rtl/convLayer.sv
`timescale 1ns/1ps

module convLayer (
    input  logic                clk,
    input  logic                rst,
    input  logic                validIn,
    input  convPkg::inColumnsT  inColumns,
    output convPkg::outColumnsT outColumns,
    output logic                validOut,
    output logic                ready
);

    import convPkg::*;

    logic                   kernelLoad;
    colIdxT                 loadCol;
    windowT                 window;
    logic                   windowValid;
    accVecT                 accVec;
    // Filters run in lockstep, bit 0 stands for all of them
    logic [NUM_FILTERS-1:0] accValid;

    // ======================================================================
    // Kernel loading and input window
    // ======================================================================
    kernelLoader i_loader (
        .clk        (clk),
        .rst        (rst),
        .kernelLoad (kernelLoad),
        .loadCol    (loadCol),
        .ready      (ready)
    );

    columnWindow i_window (
        .clk         (clk),
        .rst         (rst),
        .validIn     (validIn),
        .ready       (ready),
        .inColumns   (inColumns),
        .window      (window),
        .windowValid (windowValid)
    );

    // ======================================================================
    // Filters and output stage
    // ======================================================================
    for (genvar f = 0; f < NUM_FILTERS; f++) begin : genFilter
        convFilter #(
            .FILTER (f)
        ) i_filter (
            .clk         (clk),
            .rst         (rst),
            .kernelLoad  (kernelLoad),
            .loadCol     (loadCol),
            .window      (window),
            .windowValid (windowValid),
            .acc         (accVec[f]),
            .accValid    (accValid[f])
        );
    end

    outputQuantizer i_quantizer (
        .clk        (clk),
        .rst        (rst),
        .acc        (accVec),
        .accValid   (accValid[0]),
        .outColumns (outColumns),
        .validOut   (validOut)
    );

endmodule

// File: rtl/outputQuantizer.sv
`timescale 1ns/1ps

module outputQuantizer (
    input  logic                clk,
    input  logic                rst,
    input  convPkg::accVecT     acc,
    input  logic                accValid,
    output convPkg::outColumnsT outColumns,
    output logic                validOut
);

    import convPkg::*;

    outColumnsT quantized;

    // Drop the extra fraction bits (floor), then clamp to 16 bits
    function automatic pixelT saturate(input accT value);
        accT                           shifted;
        logic [ACC_WIDTH-DATA_WIDTH:0] upper;
        shifted = value >>> FRAC_BITS;
        upper   = shifted[ACC_WIDTH-1:DATA_WIDTH-1];
        // Fits when all upper bits equal the sign
        if (&upper || ~|upper) begin
            return shifted[DATA_WIDTH-1:0];
        end else if (shifted[ACC_WIDTH-1]) begin
            return {1'b1, {(DATA_WIDTH - 1){1'b0}}};
        end else begin
            return {1'b0, {(DATA_WIDTH - 1){1'b1}}};
        end
    endfunction

    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int r = 0; r < OUT_COL_SIZE; r++) begin
                quantized[f][r] = saturate(acc[f][r]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accValid) begin
            outColumns <= quantized;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validOut <= 1'b0;
        end else begin
            validOut <= accValid;
        end
    end

endmodule

// File: rtl/convFilter.sv
`timescale 1ns/1ps

module convFilter #(
    parameter int FILTER = 0
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     kernelLoad,
    input  convPkg::colIdxT                          loadCol,
    input  convPkg::windowT                          window,
    input  logic                                     windowValid,
    output convPkg::accT [convPkg::OUT_COL_SIZE-1:0] acc,
    output logic                                     accValid
);

    import convPkg::*;

    // One register set per kernel column
    kernelColT                kernelRegs [KERNEL_SIZE];
    kernelColT                loadColumn;
    accT [OUT_COL_SIZE-1:0]   accNext;

    // ======================================================================
    // Kernel loading
    // ======================================================================
    // Column loadCol of this filter's kernel, all channels
    always_comb begin
        for (int ch = 0; ch < IN_CHANNELS; ch++) begin
            for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
                loadColumn[ch][kr] = KERNELS[FILTER][ch][kr][loadCol];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (kernelLoad) begin
            kernelRegs[loadCol] <= loadColumn;
        end
    end

    // ======================================================================
    // Multiply-accumulate
    // ======================================================================
    // Bias starts the sum, lifted to the Q16.16 product scale
    always_comb begin
        for (int r = 0; r < OUT_COL_SIZE; r++) begin
            accNext[r] = accT'(BIASES[FILTER]) <<< FRAC_BITS;
            for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                for (int ch = 0; ch < IN_CHANNELS; ch++) begin
                    for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
                        accNext[r] = accNext[r]
                            + $signed(window[kc][ch][r + kr])
                            * $signed(kernelRegs[kc][ch][kr]);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (windowValid) begin
            acc <= accNext;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            accValid <= 1'b0;
        end else begin
            accValid <= windowValid;
        end
    end

endmodule

// File: rtl/columnWindow.sv
`timescale 1ns/1ps

module columnWindow (
    input  logic               clk,
    input  logic               rst,
    input  logic               validIn,
    input  logic               ready,
    input  convPkg::inColumnsT inColumns,
    output convPkg::windowT    window,
    output logic               windowValid
);

    import convPkg::*;

    // Accepted columns since reset, stops at KERNEL_SIZE
    logic [$clog2(KERNEL_SIZE + 1)-1:0] fillCount;
    logic accept;
    logic fullAfter;
    logic countDone;

    // Input only counts once the kernels are in place
    assign accept    = validIn && ready;
    // Window is full once the incoming column lands
    assign fullAfter = (fillCount >= KERNEL_SIZE - 1);
    assign countDone = (fillCount == KERNEL_SIZE);

    // ======================================================================
    // Column shift register
    // ======================================================================
    // New column enters at the top, the oldest drops out of slot 0
    always_ff @(posedge clk) begin
        if (accept) begin
            window <= {inColumns, window[KERNEL_SIZE-1:1]};
        end
    end

    // ======================================================================
    // Fill count and window strobe
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fillCount   <= '0;
            windowValid <= 1'b0;
        end else begin
            windowValid <= accept && fullAfter;
            if (accept && !countDone) begin
                fillCount <= fillCount + 1'b1;
            end
        end
    end

endmodule

// File: rtl/kernelLoader.sv
`timescale 1ns/1ps

module kernelLoader (
    input  logic            clk,
    input  logic            rst,
    output logic            kernelLoad,
    output convPkg::colIdxT loadCol,
    output logic            ready
);

    import convPkg::*;

    loadStateT state;
    loadStateT stateNext;
    colIdxT    colCount;
    logic      lastCol;

    // Last kernel column is being written this cycle
    assign lastCol = (colCount == colIdxT'(KERNEL_SIZE - 1));

    // ======================================================================
    // State and column counter
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= Idle;
            colCount <= '0;
        end else begin
            state <= stateNext;
            // Holds at the last column once loading is over
            if (state == Load && !lastCol) begin
                colCount <= colCount + 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            Idle: begin
                stateNext = Load;
            end
            Load: begin
                if (lastCol) begin
                    stateNext = Run;
                end
            end
            Run: begin
                stateNext = Run;
            end
            default: begin
                stateNext = Idle;
            end
        endcase
    end

    // Outputs decoded from the state
    assign kernelLoad = (state == Load);
    assign loadCol    = colCount;
    assign ready      = (state == Run);

endmodule

// File: rtl/convPkg.sv
package convPkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int DATA_WIDTH   = 16;
    localparam int FRAC_BITS    = 8;
    localparam int KERNEL_SIZE  = 3;
    localparam int COL_SIZE     = 6;
    localparam int OUT_COL_SIZE = COL_SIZE - KERNEL_SIZE + 1;
    localparam int IN_CHANNELS  = 2;
    localparam int NUM_FILTERS  = 2;
    localparam int ACC_WIDTH    = 40;

    // ======================================================================
    // Vector types
    // ======================================================================
    // Q8.8 pixel, weight or bias
    typedef logic signed [DATA_WIDTH-1:0] pixelT;
    typedef logic signed [ACC_WIDTH-1:0]  accT;
    typedef logic [1:0]                   colIdxT;

    // Input columns, indexed [channel][row]
    typedef pixelT [IN_CHANNELS-1:0][COL_SIZE-1:0] inColumnsT;
    // Output columns, indexed [filter][row]
    typedef pixelT [NUM_FILTERS-1:0][OUT_COL_SIZE-1:0] outColumnsT;
    // One kernel column of one filter, indexed [channel][row]
    typedef pixelT [IN_CHANNELS-1:0][KERNEL_SIZE-1:0] kernelColT;
    // Sliding window, indexed [column][channel][row]; column 0 is the oldest
    typedef pixelT [KERNEL_SIZE-1:0][IN_CHANNELS-1:0][COL_SIZE-1:0] windowT;
    // Accumulators, indexed [filter][row]
    typedef accT [NUM_FILTERS-1:0][OUT_COL_SIZE-1:0] accVecT;

    // Kernel loading FSM
    typedef enum logic [1:0] {Idle, Load, Run} loadStateT;

    // ======================================================================
    // Kernel and bias tables in Q8.8
    // ======================================================================
    // Indexed [filter][channel][row][column]
    localparam pixelT KERNELS [NUM_FILTERS][IN_CHANNELS][KERNEL_SIZE][KERNEL_SIZE] = '{
        // Filter 0
        '{
            '{'{16'sh0100, 16'shFF80, 16'sh0040},
              '{16'sh0080, 16'sh00C0, 16'shFFC0},
              '{16'shFF40, 16'sh0040, 16'sh0100}},
            '{'{16'sh0040, 16'sh0080, 16'shFF00},
              '{16'shFFC0, 16'sh0180, 16'sh0080},
              '{16'sh0080, 16'shFF80, 16'sh00C0}}
        },
        // Filter 1
        '{
            '{'{16'shFF80, 16'sh0040, 16'sh0080},
              '{16'sh0140, 16'shFFC0, 16'shFF00},
              '{16'sh0040, 16'sh00C0, 16'shFF80}},
            '{'{16'sh00C0, 16'shFF40, 16'sh0040},
              '{16'shFF80, 16'sh0100, 16'shFEC0},
              '{16'sh0180, 16'sh0040, 16'shFFC0}}
        }
    };

    // One bias per filter, +0.25 and -0.5
    localparam pixelT BIASES [NUM_FILTERS] = '{16'sh0040, 16'shFF80};

endpackage
